//--- analog_cfg.sv
/*
 * Sequencer that walks the J rows and then H, encodes each row onto the bit lines
 * and pulses one write word line per row with programmable high and low times.
 */
`timescale 1ns/1ns

module analog_cfg (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              cfg_load_i,
    input  ising_cfg_pkg::cfg_timing_t        cfg_i,
    input  logic                              start_i,
    // Weight memory
    output logic                              j_ren_o,
    output logic [ising_cfg_pkg::J_ADDR_W-1:0] j_raddr_o,
    input  ising_cfg_pkg::j_word_t            j_rdata_i,
    output logic                              h_ren_o,
    input  ising_cfg_pkg::wbl_row_t           h_rdata_i,
    // Analog array
    output logic [ising_cfg_pkg::NUM_SPIN-1:0] j_wwl_o,
    output logic                              h_wwl_o,
    output ising_cfg_pkg::wbl_row_t           wbl_o,
    output logic                              idle_o
);
    import ising_cfg_pkg::*;

    cfg_state_e          state_q;
    cfg_timing_t         cfg_q;
    logic [J_ADDR_W-1:0] addr_q, addr_nxt;
    logic [SEL_W-1:0]    row_sel_q, row_nxt;
    logic                h_phase_q, h_nxt;
    logic                rd_done_q;
    logic [NUM_SPIN-1:0] j_wwl_q, j_wwl_d;
    logic                h_wwl_q;
    wbl_row_t            wbl_q, wbl_d, row_raw;
    logic                high_last, low_last;
    logic                fetch_rd, load_row, load_low;
    logic                last_word, end_of_word;

    assign idle_o    = (state_q == ST_IDLE);
    assign last_word = (CNT_W'(addr_q) == cfg_q.trans_num - CNT_W'(1));

    // First word read, then the prep cycle once it has landed
    assign fetch_rd  = (state_q == ST_FETCH) && !rd_done_q;
    assign load_row  = ((state_q == ST_FETCH) && rd_done_q) ||
                       ((state_q == ST_LOW) && low_last);
    assign load_low  = (state_q == ST_HIGH) && high_last;

    // Prefetch next word (or H) so it is ready by the end of the low phase
    assign end_of_word = load_low && !h_phase_q && (row_sel_q == SEL_W'(PARALLELISM - 1));
    assign j_ren_o     = fetch_rd || (end_of_word && !last_word);
    assign h_ren_o     = end_of_word && last_word;
    assign j_raddr_o   = fetch_rd ? addr_q : addr_q + 1'b1;

    // Row that the next high phase writes
    always_comb begin
        row_nxt  = '0;
        addr_nxt = addr_q;
        h_nxt    = 1'b0;
        if (state_q == ST_LOW) begin
            if (row_sel_q != SEL_W'(PARALLELISM - 1)) begin
                row_nxt = row_sel_q + 1'b1;
            end else if (last_word) begin
                row_nxt = row_sel_q;
                h_nxt   = 1'b1;
            end else begin
                addr_nxt = addr_q + 1'b1;
            end
        end
    end

    always_comb begin
        row_raw = h_nxt ? h_rdata_i : j_rdata_i[row_nxt*ROW_W +: ROW_W];
        for (int i = 0; i < NUM_SPIN; i++) begin
            wbl_d[i*BITDATA +: BITDATA] = encode_weight(row_raw[i*BITDATA +: BITDATA]);
        end
    end

    always_comb begin
        j_wwl_d = '0;
        j_wwl_d[addr_nxt*PARALLELISM + row_nxt] = !h_nxt;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            cfg_q     <= CFG_DEFAULT;
            addr_q    <= '0;
            row_sel_q <= '0;
            h_phase_q <= 1'b0;
            rd_done_q <= 1'b0;
            j_wwl_q   <= '0;
            h_wwl_q   <= 1'b0;
            wbl_q     <= '0;
        end else begin
            rd_done_q <= fetch_rd;
            case (state_q)
                ST_IDLE: begin
                    if (cfg_load_i) begin
                        cfg_q <= cfg_i;
                    end
                    if (start_i) begin
                        state_q   <= ST_FETCH;
                        addr_q    <= '0;
                        row_sel_q <= '0;
                        h_phase_q <= 1'b0;
                    end
                end
                ST_FETCH, ST_LOW: begin
                    if (load_row) begin
                        state_q   <= ST_HIGH;
                        addr_q    <= addr_nxt;
                        row_sel_q <= row_nxt;
                        h_phase_q <= h_nxt;
                        wbl_q     <= wbl_d;
                        j_wwl_q   <= j_wwl_d;
                        h_wwl_q   <= h_nxt;
                    end
                end
                ST_HIGH: begin
                    if (high_last) begin
                        state_q <= h_phase_q ? ST_DONE : ST_LOW;
                        j_wwl_q <= '0;
                        h_wwl_q <= 1'b0;
                    end
                end
                ST_DONE: begin
                    // Low phase after the H write leaves the bit lines unchanged
                    if (low_last) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign j_wwl_o = j_wwl_q;
    assign h_wwl_o = h_wwl_q;
    assign wbl_o   = wbl_q;

    phase_counter u_high_timer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .load_i  (load_row),
        .len_i   (cfg_q.wwl_high),
        .last_o  (high_last)
    );

    phase_counter u_low_timer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .load_i  (load_low),
        .len_i   (cfg_q.wwl_low),
        .last_o  (low_last)
    );

endmodule

//--- flist.f
ising_cfg_pkg.sv
phase_counter.sv
weight_mem.sv
analog_cfg.sv
ising_cfg_top.sv
ising_cfg_props.sv
tb_ising_cfg.sv

//--- ising_cfg_pkg.sv
/*
 * Shared sizes, types and the weight encoding for the Ising-machine configuration path.
 * Imported by the weight memory, the sequencer and the top level.
 */
package ising_cfg_pkg;

    localparam int NUM_SPIN    = 16;
    localparam int BITDATA     = 4;
    localparam int PARALLELISM = 4;
    localparam int J_WORDS     = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_W    = $clog2(J_WORDS);
    localparam int ROW_W       = NUM_SPIN * BITDATA;
    localparam int WORD_W      = ROW_W * PARALLELISM;
    localparam int CNT_W       = 16;
    localparam int SEL_W       = (PARALLELISM > 1) ? $clog2(PARALLELISM) : 1;

    typedef logic [ROW_W-1:0]  wbl_row_t;
    typedef logic [WORD_W-1:0] j_word_t;

    typedef struct packed {
        logic [CNT_W-1:0] wwl_high;
        logic [CNT_W-1:0] wwl_low;
        logic [CNT_W-1:0] trans_num;
    } cfg_timing_t;

    localparam cfg_timing_t CFG_DEFAULT = '{
        wwl_high:  CNT_W'(1),
        wwl_low:   CNT_W'(1),
        trans_num: CNT_W'(J_WORDS)
    };

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_HIGH,
        ST_LOW,
        ST_DONE
    } cfg_state_e;

    // Two's complement weight to sign-magnitude array code
    // The value -8 has no code and maps to zero
    function automatic logic [BITDATA-1:0] encode_weight(input logic [BITDATA-1:0] v);
        logic [BITDATA-1:0] mag;
        mag = -v;
        if (!v[BITDATA-1]) begin
            encode_weight = (v == '0) ? '0 : {v[BITDATA-2:0], 1'b1};
        end else if (v[BITDATA-2:0] == '0) begin
            encode_weight = '0;
        end else begin
            encode_weight = {mag[BITDATA-2:0], 1'b0};
        end
    endfunction

endpackage

//--- ising_cfg_props.sv
/*
 * Word-line legality properties for the configuration sequencer.
 * Bound into every analog_cfg instance.
 */
`timescale 1ns/1ns

module ising_cfg_props (
    input logic                               clk_i,
    input logic                               reset_i,
    input logic [ising_cfg_pkg::NUM_SPIN-1:0] j_wwl_o,
    input logic                               h_wwl_o,
    input logic                               idle_o
);

    // At most one J row written at a time
    wwl_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(j_wwl_o))
        else $error("j_wwl_o has several word lines high: %h", j_wwl_o);

    j_h_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !((j_wwl_o != '0) && h_wwl_o))
        else $error("j_wwl_o and h_wwl_o high together");

    idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        idle_o |-> ((j_wwl_o == '0) && !h_wwl_o))
        else $error("word line high while idle");

endmodule

bind analog_cfg ising_cfg_props u_props (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .j_wwl_o (j_wwl_o),
    .h_wwl_o (h_wwl_o),
    .idle_o  (idle_o)
);

//--- ising_cfg_top.sv
/*
 * Top level of the Ising array configuration path.
 * Joins the weight memory to the WWL/WBL sequencer.
 */
`timescale 1ns/1ns

module ising_cfg_top (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              j_we_i,
    input  logic [ising_cfg_pkg::J_ADDR_W-1:0] j_addr_i,
    input  ising_cfg_pkg::j_word_t            j_wdata_i,
    input  logic                              h_we_i,
    input  ising_cfg_pkg::wbl_row_t           h_wdata_i,
    input  logic                              cfg_load_i,
    input  ising_cfg_pkg::cfg_timing_t        cfg_i,
    input  logic                              start_i,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0] j_wwl_o,
    output logic                              h_wwl_o,
    output ising_cfg_pkg::wbl_row_t           wbl_o,
    output logic                              idle_o
);
    import ising_cfg_pkg::*;

    logic                j_ren;
    logic [J_ADDR_W-1:0] j_raddr;
    j_word_t             j_rdata;
    logic                h_ren;
    wbl_row_t            h_rdata;

    weight_mem u_weight_mem (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .j_we_i    (j_we_i),
        .j_addr_i  (j_addr_i),
        .j_wdata_i (j_wdata_i),
        .h_we_i    (h_we_i),
        .h_wdata_i (h_wdata_i),
        .j_ren_i   (j_ren),
        .j_raddr_i (j_raddr),
        .h_ren_i   (h_ren),
        .j_rdata_o (j_rdata),
        .h_rdata_o (h_rdata)
    );

    analog_cfg u_analog_cfg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .cfg_load_i (cfg_load_i),
        .cfg_i      (cfg_i),
        .start_i    (start_i),
        .j_ren_o    (j_ren),
        .j_raddr_o  (j_raddr),
        .j_rdata_i  (j_rdata),
        .h_ren_o    (h_ren),
        .h_rdata_i  (h_rdata),
        .j_wwl_o    (j_wwl_o),
        .h_wwl_o    (h_wwl_o),
        .wbl_o      (wbl_o),
        .idle_o     (idle_o)
    );

endmodule

//--- phase_counter.sv
/*
 * Loadable countdown timer for one word-line phase.
 * last_o marks the final cycle of a phase that is len_i cycles long.
 */
`timescale 1ns/1ns

module phase_counter (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           load_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0] len_i,
    output logic                           last_o
);
    import ising_cfg_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    // Load cycle itself counts as the first cycle of the phase
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= len_i - CNT_W'(1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    // Holds at zero between phases
    assign last_o = (cnt_q == '0);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the Ising configuration testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_ising_cfg \
    -Mdir obj_dir -o sim_ising_cfg

# A failing assertion stops the simulator with a nonzero status
out=$(./obj_dir/sim_ising_cfg || true)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

//--- tb_ising_cfg.sv
/*
 * Testbench for the Ising configuration path. Fills the weight memory with random data,
 * runs several WWL/WBL transfers and checks every write pulse against a reference model.
 */
`timescale 1ns/1ns

module tb_ising_cfg;
    import ising_cfg_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 200;
    localparam int NUM_RUNS      = 4;
    // First run uses the reset defaults
    localparam int RUN_HIGH  [NUM_RUNS] = '{1, 3, 2, 2};
    localparam int RUN_LOW   [NUM_RUNS] = '{1, 2, 3, 1};
    localparam int RUN_TRANS [NUM_RUNS] = '{J_WORDS, J_WORDS, 2, J_WORDS};

    logic                clk_i = 1'b0;
    logic                reset_i;
    logic                j_we_i;
    logic [J_ADDR_W-1:0] j_addr_i;
    j_word_t             j_wdata_i;
    logic                h_we_i;
    wbl_row_t            h_wdata_i;
    logic                cfg_load_i;
    cfg_timing_t         cfg_i;
    logic                start_i;
    logic [NUM_SPIN-1:0] j_wwl_o;
    logic                h_wwl_o;
    wbl_row_t            wbl_o;
    logic                idle_o;

    integer   seed = 32'h6895_bad9;
    j_word_t  j_model [J_WORDS];
    wbl_row_t h_model;
    int       errors = 0;
    int       exp_high = 1;
    int       exp_low = 1;
    int       exp_trans = J_WORDS;
    int       pulse_cnt = 0;
    int       high_len = 0;
    int       gap_len = 0;
    int       busy_cnt = 0;
    logic     wl_prev = 1'b0;
    logic     wl_any;

    ising_cfg_top ising_cfg_top_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .j_we_i     (j_we_i),
        .j_addr_i   (j_addr_i),
        .j_wdata_i  (j_wdata_i),
        .h_we_i     (h_we_i),
        .h_wdata_i  (h_wdata_i),
        .cfg_load_i (cfg_load_i),
        .cfg_i      (cfg_i),
        .start_i    (start_i),
        .j_wwl_o    (j_wwl_o),
        .h_wwl_o    (h_wwl_o),
        .wbl_o      (wbl_o),
        .idle_o     (idle_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic int busy_cycles(input int high, input int low, input int trans);
        return 2 + (PARALLELISM * trans + 1) * (high + low);
    endfunction

    // 0 stays 0, positive v gives 2v+1, -1..-7 give 2|v| and -8 gives 0
    function automatic logic [BITDATA-1:0] array_code(input logic [BITDATA-1:0] w);
        int v;
        v = w[BITDATA-1] ? int'(w) - (1 << BITDATA) : int'(w);
        if (v > 0) begin
            return BITDATA'(2 * v + 1);
        end else if (v < 0 && v > -(1 << (BITDATA - 1))) begin
            return BITDATA'(-2 * v);
        end
        return '0;
    endfunction

    // Expected bit lines for write n with H after the J rows
    function automatic wbl_row_t expect_row(input int n);
        j_word_t  word;
        wbl_row_t raw;
        wbl_row_t row;
        if (n < PARALLELISM * exp_trans) begin
            word = j_model[n / PARALLELISM];
            raw  = word[(n % PARALLELISM) * ROW_W +: ROW_W];
        end else begin
            raw = h_model;
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            row[i*BITDATA +: BITDATA] = array_code(raw[i*BITDATA +: BITDATA]);
        end
        return row;
    endfunction

    function automatic logic [NUM_SPIN-1:0] expect_wwl(input int n);
        if (n < PARALLELISM * exp_trans) begin
            return NUM_SPIN'(1) << n;
        end
        return '0;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic write_j_word(input int addr, input j_word_t data);
        j_we_i    = 1'b1;
        j_addr_i  = J_ADDR_W'(addr);
        j_wdata_i = data;
        next_cycle();
        j_we_i = 1'b0;
        j_model[addr] = data;
    endtask

    task automatic write_h_row(input wbl_row_t data);
        h_we_i    = 1'b1;
        h_wdata_i = data;
        next_cycle();
        h_we_i  = 1'b0;
        h_model = data;
    endtask

    task automatic fill_word(input int addr, input bit corner);
        j_word_t w;
        for (int b = 0; b < WORD_W / 32; b++) begin
            w[b*32 +: 32] = $random(seed);
        end
        // Most negative weight and a few edge values in row 0
        if (corner) begin
            w[3:0]   = 4'h8;
            w[7:4]   = 4'hf;
            w[11:8]  = 4'h7;
            w[15:12] = 4'h0;
        end
        write_j_word(addr, w);
    endtask

    task automatic fill_h_row();
        wbl_row_t h;
        for (int b = 0; b < ROW_W / 32; b++) begin
            h[b*32 +: 32] = $random(seed);
        end
        write_h_row(h);
    endtask

    task automatic run_transfer(input int high, input int low, input int trans,
                                input bit load, input bit poke_busy);
        int expected;
        expected = busy_cycles(high, low, trans);
        if (load) begin
            cfg_i = '{wwl_high: CNT_W'(high), wwl_low: CNT_W'(low), trans_num: CNT_W'(trans)};
            cfg_load_i = 1'b1;
            next_cycle();
            cfg_load_i = 1'b0;
        end
        exp_high  = high;
        exp_low   = low;
        exp_trans = trans;
        pulse_cnt = 0;
        busy_cnt  = 0;
        high_len  = 0;
        gap_len   = 0;
        start_i   = 1'b1;
        next_cycle();
        start_i = 1'b0;
        if (poke_busy) begin
            repeat (9) next_cycle();
            start_i = 1'b1;
            next_cycle();
            start_i = 1'b0;
        end
        while (idle_o !== 1'b1) begin
            next_cycle();
        end
        if (busy_cnt != expected) begin
            $display("ERROR busy_cycles: expected %h, got %h", expected, busy_cnt);
            errors++;
        end
        if (pulse_cnt != PARALLELISM * trans + 1) begin
            $display("ERROR pulse_cnt: expected %h, got %h", PARALLELISM * trans + 1, pulse_cnt);
            errors++;
        end
        // Low phase after the H write
        if (gap_len != low) begin
            $display("ERROR wwl_low_cycles: expected %h, got %h", low, gap_len);
            errors++;
        end
    endtask

    // Compares every word-line cycle in the middle of the clock period
    always @(negedge clk_i) begin
        wl_any = (j_wwl_o != '0) || h_wwl_o;
        if (!reset_i) begin
            if (!idle_o) begin
                busy_cnt++;
            end
            if (idle_o && wl_any) begin
                $display("Word line high while the sequencer reports idle");
                errors++;
            end
            if (wl_any) begin
                if (!wl_prev && pulse_cnt > 0 && gap_len != exp_low) begin
                    $display("ERROR wwl_low_cycles: expected %h, got %h", exp_low, gap_len);
                    errors++;
                end
                if (j_wwl_o != expect_wwl(pulse_cnt)) begin
                    $display("ERROR j_wwl_o: expected %h, got %h", expect_wwl(pulse_cnt), j_wwl_o);
                    errors++;
                end
                if (h_wwl_o != (pulse_cnt == PARALLELISM * exp_trans)) begin
                    $display("ERROR h_wwl_o: expected %h, got %h",
                             pulse_cnt == PARALLELISM * exp_trans, h_wwl_o);
                    errors++;
                end
                if (wbl_o != expect_row(pulse_cnt)) begin
                    $display("ERROR wbl_o: expected %h, got %h", expect_row(pulse_cnt), wbl_o);
                    errors++;
                end
                high_len++;
            end else begin
                if (wl_prev) begin
                    if (high_len != exp_high) begin
                        $display("ERROR wwl_high_cycles: expected %h, got %h", exp_high, high_len);
                        errors++;
                    end
                    pulse_cnt++;
                    gap_len = 0;
                end
                high_len = 0;
                if (!idle_o) begin
                    gap_len++;
                end
            end
            wl_prev = wl_any;
        end
    end

    initial begin
        int limit;
        limit = RESET_CYCLES + MARGIN_CYCLES;
        for (int k = 0; k < NUM_RUNS; k++) begin
            limit += busy_cycles(RUN_HIGH[k], RUN_LOW[k], RUN_TRANS[k]);
        end
        #(limit * CLK_PERIOD);
        $display("Timeout after %0d cycles, the sequencer did not finish", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset_i    = 1'b1;
        j_we_i     = 1'b0;
        j_addr_i   = '0;
        j_wdata_i  = '0;
        h_we_i     = 1'b0;
        h_wdata_i  = '0;
        cfg_load_i = 1'b0;
        cfg_i      = '0;
        start_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        if (idle_o !== 1'b1 || j_wwl_o !== '0 || h_wwl_o !== 1'b0 || wbl_o !== '0) begin
            $display("Outputs not in their reset state after reset");
            errors++;
        end

        for (int a = 0; a < J_WORDS; a++) begin
            fill_word(a, a == 0);
        end
        fill_h_row();

        for (int k = 0; k < NUM_RUNS; k++) begin
            // New data between runs for the last transfer
            if (k == NUM_RUNS - 1) begin
                fill_word(1, 1'b0);
                fill_h_row();
            end
            run_transfer(RUN_HIGH[k], RUN_LOW[k], RUN_TRANS[k], k != 0, k == NUM_RUNS - 1);
        end

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- weight_mem.sv
/*
 * Weight store for J words and the H row, filled by the host while the sequencer is idle.
 * Both read ports have one cycle of latency.
 */
`timescale 1ns/1ns

module weight_mem (
    input  logic                              clk_i,
    input  logic                              reset_i,
    // Host write port
    input  logic                              j_we_i,
    input  logic [ising_cfg_pkg::J_ADDR_W-1:0] j_addr_i,
    input  ising_cfg_pkg::j_word_t            j_wdata_i,
    input  logic                              h_we_i,
    input  ising_cfg_pkg::wbl_row_t           h_wdata_i,
    // Sequencer read port
    input  logic                              j_ren_i,
    input  logic [ising_cfg_pkg::J_ADDR_W-1:0] j_raddr_i,
    input  logic                              h_ren_i,
    output ising_cfg_pkg::j_word_t            j_rdata_o,
    output ising_cfg_pkg::wbl_row_t           h_rdata_o
);
    import ising_cfg_pkg::*;

    j_word_t  j_mem_q [J_WORDS];
    wbl_row_t h_row_q;

    always_ff @(posedge clk_i) begin
        if (j_we_i) begin
            j_mem_q[j_addr_i] <= j_wdata_i;
        end
        if (h_we_i) begin
            h_row_q <= h_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            j_rdata_o <= '0;
            h_rdata_o <= '0;
        end else begin
            if (j_ren_i) begin
                j_rdata_o <= j_mem_q[j_raddr_i];
            end
            if (h_ren_i) begin
                h_rdata_o <= h_row_q;
            end
        end
    end

endmodule
